//--- logic/mm_ram.sv
// word RAM with instruction, data and program load ports plus peripheral range decode
`timescale 1ns/1ps

module mm_ram #(
  parameter int RAM_ADDR_WIDTH = 12
) (
  input  logic              clk_i,
  input  logic              rst_n_i,

  input  seq_pkg::mem_req_t instr_req_i,
  output seq_pkg::mem_rsp_t instr_rsp_o,

  input  seq_pkg::mem_req_t data_req_i,
  output seq_pkg::mem_rsp_t data_rsp_o,

  input  logic              load_we_i,
  input  logic [31:0]       load_addr_i,
  input  logic [31:0]       load_data_i,

  output logic              periph_we_o,
  output logic [31:0]       periph_addr_o,
  output logic [31:0]       periph_wdata_o
);

  localparam int WORDS = 2 ** (RAM_ADDR_WIDTH - 2);

  logic [31:0]               mem [WORDS];

  logic [RAM_ADDR_WIDTH-3:0] instr_idx;
  logic [RAM_ADDR_WIDTH-3:0] data_idx;
  logic [RAM_ADDR_WIDTH-3:0] load_idx;
  logic                      data_periph;

  // shared write path
  logic                      wr_en;
  logic [RAM_ADDR_WIDTH-3:0] wr_idx;
  logic [31:0]               wr_data;

  logic                      instr_rvalid_q;
  logic                      data_rvalid_q;
  logic [31:0]               instr_rdata_q;
  logic [31:0]               data_rdata_q;

  // all accesses are whole words so the two low address bits are dropped
  assign instr_idx = instr_req_i.addr[RAM_ADDR_WIDTH-1:2];
  assign data_idx  = data_req_i.addr[RAM_ADDR_WIDTH-1:2];
  assign load_idx  = load_addr_i[RAM_ADDR_WIDTH-1:2];

  // everything from PERIPH_BASE upward belongs to the register block
  assign data_periph = (data_req_i.addr >= seq_pkg::PERIPH_BASE);

  // the load port wins over a data store in the same cycle
  always_comb begin
    wr_en   = 1'b0;
    wr_idx  = data_idx;
    wr_data = data_req_i.wdata;
    if (load_we_i) begin
      wr_en   = 1'b1;
      wr_idx  = load_idx;
      wr_data = load_data_i;
    end else if (data_req_i.req && data_req_i.we && !data_periph) begin
      wr_en = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem[wr_idx] <= wr_data;
    end
    if (instr_req_i.req) begin
      instr_rdata_q <= mem[instr_idx];
    end
    // peripheral reads come back as zero
    if (data_req_i.req && !data_req_i.we) begin
      data_rdata_q <= data_periph ? 32'd0 : mem[data_idx];
    end
  end

  // every request is granted at once, so rvalid is just the request delayed
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      instr_rvalid_q <= 1'b0;
      data_rvalid_q  <= 1'b0;
    end else begin
      instr_rvalid_q <= instr_req_i.req;
      data_rvalid_q  <= data_req_i.req;
    end
  end

  assign instr_rsp_o = '{
    gnt:    instr_req_i.req,
    rvalid: instr_rvalid_q,
    rdata:  instr_rdata_q
  };

  assign data_rsp_o = '{
    gnt:    data_req_i.req,
    rvalid: data_rvalid_q,
    rdata:  data_rdata_q
  };

  // granted peripheral stores are forwarded for exactly the grant cycle
  assign periph_we_o    = data_req_i.req && data_req_i.we && data_periph;
  assign periph_addr_o  = data_req_i.addr;
  assign periph_wdata_o = data_req_i.wdata;

endmodule

//--- logic/mmio_periph.sv
// test verdict flags and exit value register written by peripheral stores
`timescale 1ns/1ps

module mmio_periph (
  input  logic        clk_i,
  input  logic        rst_n_i,

  input  logic        periph_we_i,
  input  logic [31:0] periph_addr_i,
  input  logic [31:0] periph_wdata_i,

  output logic        tests_passed_o,
  output logic        tests_failed_o,
  output logic        exit_valid_o,
  output logic [31:0] exit_value_o
);

  logic        passed_q;
  logic        failed_q;
  logic        exit_valid_q;
  logic [31:0] exit_value_q;

  // all four outputs hold their value until the next reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      passed_q     <= 1'b0;
      failed_q     <= 1'b0;
      exit_valid_q <= 1'b0;
      exit_value_q <= 32'd0;
    end else if (periph_we_i) begin
      case (periph_addr_i)
        seq_pkg::PASS_ADDR: begin
          // only the magic value counts as a pass, anything else is a fail
          if (periph_wdata_i == seq_pkg::PASS_MAGIC) begin
            passed_q <= 1'b1;
          end else begin
            failed_q <= 1'b1;
          end
        end
        seq_pkg::EXIT_ADDR: begin
          exit_value_q <= periph_wdata_i;
          exit_valid_q <= 1'b1;
        end
        default: begin
          // other peripheral addresses have no register behind them
        end
      endcase
    end
  end

  assign tests_passed_o = passed_q;
  assign tests_failed_o = failed_q;
  assign exit_valid_o   = exit_valid_q;
  assign exit_value_o   = exit_value_q;

endmodule

//--- logic/seq_core.sv
// multi-cycle fetch, decode and execute FSM with an eight-entry register file
`timescale 1ns/1ps

module seq_core #(
  parameter logic [31:0] BOOT_ADDR = 32'h0
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              fetch_enable_i,
  output seq_pkg::mem_req_t instr_req_o,
  input  seq_pkg::mem_rsp_t instr_rsp_i,
  output seq_pkg::mem_req_t data_req_o,
  input  seq_pkg::mem_rsp_t data_rsp_i
);

  typedef enum logic [2:0] {
    FETCH,
    WAIT_INSTR,
    EXECUTE,
    DATA_REQ,
    DATA_WAIT,
    HALT
  } state_e;

  state_e               state_q;
  logic [31:0]          pc_q;
  logic [31:0]          regs_q [8];
  seq_pkg::seq_instr_u  instr_q;

  // latched data access, stable while the request is pending
  logic                 data_we_q;
  logic [31:0]          data_addr_q;
  logic [31:0]          data_wdata_q;

  seq_pkg::seq_op_e     op;
  logic [2:0]           rd_idx;
  logic [2:0]           rs_idx;
  logic [2:0]           rt_idx;
  logic [31:0]          rd_val;
  logic [31:0]          rs_val;
  logic [31:0]          rt_val;
  logic [31:0]          imm_sext;
  logic [31:0]          alu_res;
  logic                 bne_taken;
  logic [31:0]          pc_next;

  // op, rd and rs line up in both views, only rt needs the register view
  assign op       = instr_q.imm_view.op;
  assign rd_idx   = instr_q.imm_view.rd;
  assign rs_idx   = instr_q.imm_view.rs;
  assign rt_idx   = instr_q.reg_view.rt;
  assign imm_sext = {{16{instr_q.imm_view.imm[15]}}, instr_q.imm_view.imm};

  // r0 reads as zero whatever was stored
  assign rd_val = (rd_idx == 3'd0) ? 32'd0 : regs_q[rd_idx];
  assign rs_val = (rs_idx == 3'd0) ? 32'd0 : regs_q[rs_idx];
  assign rt_val = (rt_idx == 3'd0) ? 32'd0 : regs_q[rt_idx];

  // the adder also forms the effective address for LW and SW
  always_comb begin
    case (op)
      seq_pkg::OP_ADD: alu_res = rs_val + rt_val;
      seq_pkg::OP_SUB: alu_res = rs_val - rt_val;
      default:         alu_res = rs_val + imm_sext;
    endcase
  end

  // branch offset counts words from the BNE itself
  assign bne_taken = (op == seq_pkg::OP_BNE) && (rs_val != rd_val);
  assign pc_next   = bne_taken ? pc_q + {imm_sext[29:0], 2'b00} : pc_q + 32'd4;

  assign instr_req_o = '{
    req:   (state_q == FETCH) && fetch_enable_i,
    we:    1'b0,
    addr:  pc_q,
    wdata: 32'd0
  };

  assign data_req_o = '{
    req:   (state_q == DATA_REQ),
    we:    data_we_q,
    addr:  data_addr_q,
    wdata: data_wdata_q
  };

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= FETCH;
      pc_q    <= BOOT_ADDR;
      for (int i = 0; i < 8; i++) begin
        regs_q[i] <= 32'd0;
      end
    end else begin
      case (state_q)
        FETCH: begin
          if (instr_req_o.req && instr_rsp_i.gnt) begin
            state_q <= WAIT_INSTR;
          end
        end
        WAIT_INSTR: begin
          if (instr_rsp_i.rvalid) begin
            state_q <= EXECUTE;
          end
        end
        EXECUTE: begin
          pc_q <= pc_next;
          case (op)
            seq_pkg::OP_ADDI, seq_pkg::OP_ADD, seq_pkg::OP_SUB: begin
              if (rd_idx != 3'd0) begin
                regs_q[rd_idx] <= alu_res;
              end
              state_q <= FETCH;
            end
            seq_pkg::OP_LW, seq_pkg::OP_SW: state_q <= DATA_REQ;
            default:                        state_q <= FETCH;
          endcase
        end
        DATA_REQ: begin
          if (data_rsp_i.gnt) begin
            state_q <= DATA_WAIT;
          end
        end
        DATA_WAIT: begin
          if (data_rsp_i.rvalid) begin
            if (!data_we_q && rd_idx != 3'd0) begin
              regs_q[rd_idx] <= data_rsp_i.rdata;
            end
            // a completed store to the exit register ends the program
            if (data_we_q && data_addr_q == seq_pkg::EXIT_ADDR) begin
              state_q <= HALT;
            end else begin
              state_q <= FETCH;
            end
          end
        end
        default: state_q <= HALT;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == WAIT_INSTR && instr_rsp_i.rvalid) begin
      instr_q <= instr_rsp_i.rdata;
    end
    if (state_q == EXECUTE) begin
      data_we_q    <= (op == seq_pkg::OP_SW);
      data_addr_q  <= alu_res;
      data_wdata_q <= rd_val;
    end
  end

endmodule

//--- logic/seq_pkg.sv
// opcodes, instruction word union, memory port structs and peripheral address map
package seq_pkg;

  // opcode sits in the top nibble of every instruction word
  typedef enum logic [3:0] {
    OP_HALT_NOP = 4'h0,
    OP_ADDI     = 4'h1,
    OP_ADD      = 4'h2,
    OP_SUB      = 4'h3,
    OP_LW       = 4'h4,
    OP_SW       = 4'h5,
    OP_BNE      = 4'h6
  } seq_op_e;

  // immediate format used by ADDI, LW, SW and BNE
  // for SW and BNE the rd field names the second source register
  typedef struct packed {
    seq_op_e            op;
    logic [2:0]         rd;
    logic [2:0]         rs;
    logic [5:0]         unused;
    logic signed [15:0] imm;
  } seq_instr_imm_t;

  // register format used by ADD and SUB
  typedef struct packed {
    seq_op_e     op;
    logic [2:0]  rd;
    logic [2:0]  rs;
    logic [2:0]  rt;
    logic [18:0] unused;
  } seq_instr_reg_t;

  // both views share op, rd and rs at the same bit positions
  typedef union packed {
    seq_instr_imm_t imm_view;
    seq_instr_reg_t reg_view;
  } seq_instr_u;

  // master to memory, held stable until gnt
  typedef struct packed {
    logic        req;
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
  } mem_req_t;

  // memory to master, rvalid follows the grant cycle by one
  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
  } mem_rsp_t;

  // pseudo peripheral map above the RAM
  localparam logic [31:0] PERIPH_BASE = 32'h2000_0000;
  localparam logic [31:0] PASS_ADDR   = PERIPH_BASE;
  localparam logic [31:0] EXIT_ADDR   = PERIPH_BASE + 32'd4;

  // value written to PASS_ADDR that marks a passing test
  localparam logic [31:0] PASS_MAGIC  = 32'd123456789;

endpackage

//--- logic/seq_subsystem.sv
// top level joining the sequencer core, the RAM and the verdict peripheral
`timescale 1ns/1ps

module seq_subsystem #(
  parameter int          RAM_ADDR_WIDTH = 12,
  parameter logic [31:0] BOOT_ADDR      = 32'h0
) (
  input  logic        clk_i,
  input  logic        rst_n_i,

  input  logic        fetch_enable_i,

  input  logic        load_we_i,
  input  logic [31:0] load_addr_i,
  input  logic [31:0] load_data_i,

  output logic        tests_passed_o,
  output logic        tests_failed_o,
  output logic        exit_valid_o,
  output logic [31:0] exit_value_o
);

  // core to memory ports
  seq_pkg::mem_req_t instr_req;
  seq_pkg::mem_rsp_t instr_rsp;
  seq_pkg::mem_req_t data_req;
  seq_pkg::mem_rsp_t data_rsp;

  // stores that fall into the peripheral range
  logic              periph_we;
  logic [31:0]       periph_addr;
  logic [31:0]       periph_wdata;

  seq_core #(
    .BOOT_ADDR(BOOT_ADDR)
  ) i_core (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .fetch_enable_i(fetch_enable_i),
    .instr_req_o   (instr_req),
    .instr_rsp_i   (instr_rsp),
    .data_req_o    (data_req),
    .data_rsp_i    (data_rsp)
  );

  // the RAM also splits off the peripheral range from the data port
  mm_ram #(
    .RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)
  ) i_ram (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .instr_req_i   (instr_req),
    .instr_rsp_o   (instr_rsp),
    .data_req_i    (data_req),
    .data_rsp_o    (data_rsp),
    .load_we_i     (load_we_i),
    .load_addr_i   (load_addr_i),
    .load_data_i   (load_data_i),
    .periph_we_o   (periph_we),
    .periph_addr_o (periph_addr),
    .periph_wdata_o(periph_wdata)
  );

  mmio_periph i_periph (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .periph_we_i   (periph_we),
    .periph_addr_i (periph_addr),
    .periph_wdata_i(periph_wdata),
    .tests_passed_o(tests_passed_o),
    .tests_failed_o(tests_failed_o),
    .exit_valid_o  (exit_valid_o),
    .exit_value_o  (exit_value_o)
  );

endmodule

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line in the log
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module tb_seq_subsystem \
  -f verilog.f -o tb_sim > sim.log 2>&1 &&
  ./obj_dir/tb_sim >> sim.log 2>&1 ||
  echo "build or simulation did not complete" >> sim.log
grep -q "^All tests passed$" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

//--- testbench/tb_programs.svh
// test program table, instruction encoders, expected exit values and expected verdicts
localparam int NUM_TESTS    = 7;
localparam int MAX_WORDS    = 32;
localparam int VERDICT_NONE = 0;
localparam int VERDICT_PASS = 1;
localparam int VERDICT_FAIL = 2;

// two data words placed above the code of every program
localparam int BASE_ADDR    = 248;
localparam int MAGIC_ADDR   = 252;

logic [31:0] prog_words [NUM_TESTS][MAX_WORDS];
int          prog_len [NUM_TESTS];
logic [31:0] exp_exit [NUM_TESTS];
int          exp_verdict [NUM_TESTS];
int          hold_cycles [NUM_TESTS];

// op, rd, rs, six spare bits, then a signed 16-bit immediate
function automatic logic [31:0] enc_imm(input seq_pkg::seq_op_e op, input int rd, input int rs,
                                        input int imm);
  return {op, rd[2:0], rs[2:0], 6'd0, imm[15:0]};
endfunction

// op, rd, rs, rt and the spare low bits
function automatic logic [31:0] enc_reg(input seq_pkg::seq_op_e op, input int rd, input int rs,
                                        input int rt);
  return {op, rd[2:0], rs[2:0], rt[2:0], 19'd0};
endfunction

function automatic void add_word(input int t, input logic [31:0] w);
  prog_words[t][prog_len[t]] = w;
  prog_len[t] = prog_len[t] + 1;
endfunction

task automatic build_programs();
  int seed;
  int a;
  int b;
  int c;
  seed = 39389;
  for (int t = 0; t < NUM_TESTS; t++) begin
    prog_len[t]    = 0;
    hold_cycles[t] = 0;
    exp_verdict[t] = VERDICT_NONE;
    // r7 holds the peripheral base in every program
    add_word(t, enc_imm(seq_pkg::OP_LW, 7, 0, BASE_ADDR));
  end

  // arithmetic chain, the write to r0 must not stick
  add_word(0, enc_imm(seq_pkg::OP_ADDI, 1, 0, 100));
  add_word(0, enc_imm(seq_pkg::OP_ADDI, 2, 0, -30));
  add_word(0, enc_imm(seq_pkg::OP_ADDI, 0, 0, 55));
  add_word(0, enc_reg(seq_pkg::OP_ADD, 3, 1, 0));
  add_word(0, enc_reg(seq_pkg::OP_SUB, 4, 2, 1));
  add_word(0, enc_reg(seq_pkg::OP_ADD, 5, 3, 4));
  add_word(0, enc_imm(seq_pkg::OP_ADDI, 5, 5, -7));
  add_word(0, enc_imm(seq_pkg::OP_SW, 5, 7, 4));
  exp_exit[0] = (100 + 0) + (-30 - 100) - 7;

  // store to RAM and load the word back into another register
  add_word(1, enc_imm(seq_pkg::OP_ADDI, 1, 0, -4660));
  add_word(1, enc_imm(seq_pkg::OP_SW, 1, 0, 512));
  add_word(1, enc_imm(seq_pkg::OP_LW, 2, 0, 512));
  add_word(1, enc_imm(seq_pkg::OP_SW, 2, 7, 4));
  exp_exit[1] = -4660;

  // count r1 down from 10 and sum into r2, the branch jumps back two words
  add_word(2, enc_imm(seq_pkg::OP_ADDI, 1, 0, 10));
  add_word(2, enc_imm(seq_pkg::OP_ADDI, 2, 0, 0));
  add_word(2, enc_reg(seq_pkg::OP_ADD, 2, 2, 1));
  add_word(2, enc_imm(seq_pkg::OP_ADDI, 1, 1, -1));
  add_word(2, enc_imm(seq_pkg::OP_BNE, 0, 1, -2));
  add_word(2, enc_imm(seq_pkg::OP_SW, 2, 7, 4));
  exp_exit[2] = 10 * 11 / 2;

  add_word(3, enc_imm(seq_pkg::OP_LW, 6, 0, MAGIC_ADDR));
  add_word(3, enc_imm(seq_pkg::OP_SW, 6, 7, 0));
  add_word(3, enc_imm(seq_pkg::OP_ADDI, 1, 0, 1));
  add_word(3, enc_imm(seq_pkg::OP_SW, 1, 7, 4));
  exp_exit[3]    = 1;
  exp_verdict[3] = VERDICT_PASS;

  add_word(4, enc_imm(seq_pkg::OP_ADDI, 6, 0, 99));
  add_word(4, enc_imm(seq_pkg::OP_SW, 6, 7, 0));
  add_word(4, enc_imm(seq_pkg::OP_ADDI, 1, 0, 2));
  add_word(4, enc_imm(seq_pkg::OP_SW, 1, 7, 4));
  exp_exit[4]    = 2;
  exp_verdict[4] = VERDICT_FAIL;

  // random immediates stay inside the signed 16-bit range
  a = $random(seed) % 30000;
  b = $random(seed) % 30000;
  c = $random(seed) % 30000;
  add_word(5, enc_imm(seq_pkg::OP_ADDI, 1, 0, a));
  add_word(5, enc_imm(seq_pkg::OP_ADDI, 2, 1, b));
  add_word(5, enc_imm(seq_pkg::OP_ADDI, 4, 0, c));
  add_word(5, enc_reg(seq_pkg::OP_SUB, 3, 2, 4));
  add_word(5, enc_imm(seq_pkg::OP_SW, 3, 7, 4));
  exp_exit[5] = a + b - c;

  add_word(6, enc_imm(seq_pkg::OP_ADDI, 1, 0, 77));
  add_word(6, enc_imm(seq_pkg::OP_SW, 1, 7, 4));
  exp_exit[6]    = 77;
  hold_cycles[6] = 200;
endtask

//--- testbench/tb_seq_subsystem.sv
// testbench that loads each table program, runs it and checks exit and verdict
`timescale 1ns/1ps

module tb_seq_subsystem;

  localparam int TIMEOUT_CYCLES = 2000;

  logic        clk;
  logic        rst_n;
  logic        fetch_en;
  logic        load_we;
  logic [31:0] load_addr;
  logic [31:0] load_data;
  logic        passed;
  logic        failed;
  logic        exit_valid;
  logic [31:0] exit_value;

  int          errors;
  int          timeouts;

  `include "tb_programs.svh"

  seq_subsystem #(
    .RAM_ADDR_WIDTH(12),
    .BOOT_ADDR     (32'h0)
  ) i_dut (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .fetch_enable_i(fetch_en),
    .load_we_i     (load_we),
    .load_addr_i   (load_addr),
    .load_data_i   (load_data),
    .tests_passed_o(passed),
    .tests_failed_o(failed),
    .exit_valid_o  (exit_valid),
    .exit_value_o  (exit_value)
  );

  always #2 clk = ~clk;

  // starts and ends on a falling edge, the RAM takes the word on the rising edge between
  task automatic load_word(input logic [31:0] addr, input logic [31:0] data);
    load_we   = 1'b1;
    load_addr = addr;
    load_data = data;
    @(negedge clk);
    load_we   = 1'b0;
  endtask

  task automatic run_test(input int t);
    int cycles;
    fetch_en = 1'b0;
    rst_n    = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < prog_len[t]; i++) begin
      load_word(i * 4, prog_words[t][i]);
    end
    load_word(BASE_ADDR, 32'h2000_0000);
    load_word(MAGIC_ADDR, 32'd123456789);
    // nothing may run while the enable is low
    for (int i = 0; i < hold_cycles[t]; i++) begin
      @(negedge clk);
      if (exit_valid) begin
        $display("Error at %0t: test %0d exit_valid_o high with fetch disabled", $time, t);
        errors++;
      end
    end
    fetch_en = 1'b1;
    cycles   = 0;
    while (!exit_valid && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    if (!exit_valid) begin
      $display("Test %0d: the program did not finish within %0d cycles", t, TIMEOUT_CYCLES);
      timeouts++;
    end else begin
      if (exit_value !== exp_exit[t]) begin
        $display("Error at %0t: test %0d exit value %h, expected %h", $time, t, exit_value,
                 exp_exit[t]);
        errors++;
      end
      if (passed !== (exp_verdict[t] == VERDICT_PASS)) begin
        $display("Error at %0t: test %0d tests_passed_o is %b", $time, t, passed);
        errors++;
      end
      if (failed !== (exp_verdict[t] == VERDICT_FAIL)) begin
        $display("Error at %0t: test %0d tests_failed_o is %b", $time, t, failed);
        errors++;
      end
    end
  endtask

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    fetch_en  = 1'b0;
    load_we   = 1'b0;
    load_addr = 32'd0;
    load_data = 32'd0;
    errors    = 0;
    timeouts  = 0;
    build_programs();
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("Checks done with %0d errors and %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+testbench
logic/seq_pkg.sv
logic/seq_core.sv
logic/mm_ram.sv
logic/mmio_periph.sv
logic/seq_subsystem.sv
testbench/tb_seq_subsystem.sv
